//--- compile.f
soc_pkg.sv
tcb_arbiter.sv
tcb_decoder.sv
tcb_memory.sv
tcb_gpio.sv
soc_top.sv
tb_soc_top.sv

//--- soc_pkg.sv
`default_nettype none

package soc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus geometry
    ////////////////////////////////////////////////////////////////////////////

    // data and address width
    localparam int unsigned xlen = 32;
    // size field, log2 of byte count
    localparam int unsigned siz_w = 2;
    // managers sharing the system bus
    localparam int unsigned n_man = 2;

    ////////////////////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////////////////////

    // word index width, 1024 words of data memory
    localparam int unsigned mem_adr = 10;
    // region bit, set for peripherals
    localparam int unsigned per_bit = 12;

    // GPIO register offsets inside the GPIO group
    localparam logic [5:0] gpio_out_ofs = 6'h00;
    localparam logic [5:0] gpio_ena_ofs = 6'h04;
    localparam logic [5:0] gpio_in_ofs  = 6'h08;

    // one address word, two decodings
    typedef union packed {
        // data memory view
        struct packed {
            logic [xlen-per_bit-2:0] top;  // must be zero
            logic                    rgn;  // 0 for memory
            logic [mem_adr-1:0]      idx;  // word index
            logic [1:0]              ofs;  // byte offset
        } mem;
        // peripheral view
        struct packed {
            logic [xlen-per_bit-2:0] top;  // must be zero
            logic                    rgn;  // 1 for peripherals
            logic [per_bit-8:0]      rsv;  // not decoded, aliases
            logic                    grp;  // 0 selects GPIO
            logic [5:0]              ofs;  // register offset
        } per;
    } tcb_adr_t;

endpackage

`default_nettype wire

//--- soc_top.sv
`timescale 1ns/10ps
`default_nettype none

module soc_top (
    // system signals
    input  logic                      clk,
    input  logic                      rst_n,
    // manager port 0, core load/store
    input  logic                      m0_vld,
    input  logic                      m0_wen,
    input  logic [soc_pkg::xlen-1:0]  m0_adr,
    input  logic [soc_pkg::siz_w-1:0] m0_siz,
    input  logic [soc_pkg::xlen-1:0]  m0_wdt,
    output logic                      m0_rdy,
    output logic [soc_pkg::xlen-1:0]  m0_rdt,
    output logic                      m0_err,
    // manager port 1, DMA/debug
    input  logic                      m1_vld,
    input  logic                      m1_wen,
    input  logic [soc_pkg::xlen-1:0]  m1_adr,
    input  logic [soc_pkg::siz_w-1:0] m1_siz,
    input  logic [soc_pkg::xlen-1:0]  m1_wdt,
    output logic                      m1_rdy,
    output logic [soc_pkg::xlen-1:0]  m1_rdt,
    output logic                      m1_err,
    // GPIO pins
    output logic [soc_pkg::xlen-1:0]  gpio_o,
    output logic [soc_pkg::xlen-1:0]  gpio_e,
    input  logic [soc_pkg::xlen-1:0]  gpio_i
);

    // shared bus between arbiter and decoder
    logic                      bus_vld;
    logic                      bus_wen;
    logic [soc_pkg::xlen-1:0]  bus_adr;
    logic [soc_pkg::siz_w-1:0] bus_siz;
    logic [soc_pkg::xlen-1:0]  bus_wdt;
    logic                      bus_rdy;
    logic [soc_pkg::xlen-1:0]  bus_rdt;
    logic                      bus_err;

    // data memory branch
    logic                      mem_vld;
    logic                      mem_wen;
    logic [soc_pkg::xlen-1:0]  mem_adr;
    logic [soc_pkg::siz_w-1:0] mem_siz;
    logic [soc_pkg::xlen-1:0]  mem_wdt;
    logic [soc_pkg::xlen-1:0]  mem_rdt;

    // GPIO branch
    logic                      gpio_vld;
    logic                      gpio_wen;
    logic [soc_pkg::xlen-1:0]  gpio_adr;
    logic [soc_pkg::xlen-1:0]  gpio_wdt;
    logic [soc_pkg::xlen-1:0]  gpio_rdt;

    ////////////////////////////////////////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////////////////////////////////////////

    // two managers onto one bus
    tcb_arbiter arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .m0_vld  (m0_vld),
        .m0_wen  (m0_wen),
        .m0_adr  (m0_adr),
        .m0_siz  (m0_siz),
        .m0_wdt  (m0_wdt),
        .m0_rdy  (m0_rdy),
        .m0_rdt  (m0_rdt),
        .m0_err  (m0_err),
        .m1_vld  (m1_vld),
        .m1_wen  (m1_wen),
        .m1_adr  (m1_adr),
        .m1_siz  (m1_siz),
        .m1_wdt  (m1_wdt),
        .m1_rdy  (m1_rdy),
        .m1_rdt  (m1_rdt),
        .m1_err  (m1_err),
        .bus_vld (bus_vld),
        .bus_wen (bus_wen),
        .bus_adr (bus_adr),
        .bus_siz (bus_siz),
        .bus_wdt (bus_wdt),
        .bus_rdy (bus_rdy),
        .bus_rdt (bus_rdt),
        .bus_err (bus_err)
    );

    // memory / GPIO / error
    tcb_decoder dec (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus_vld  (bus_vld),
        .bus_wen  (bus_wen),
        .bus_adr  (bus_adr),
        .bus_siz  (bus_siz),
        .bus_wdt  (bus_wdt),
        .bus_rdy  (bus_rdy),
        .bus_rdt  (bus_rdt),
        .bus_err  (bus_err),
        .mem_vld  (mem_vld),
        .mem_wen  (mem_wen),
        .mem_adr  (mem_adr),
        .mem_siz  (mem_siz),
        .mem_wdt  (mem_wdt),
        .mem_rdt  (mem_rdt),
        .gpio_vld (gpio_vld),
        .gpio_wen (gpio_wen),
        .gpio_adr (gpio_adr),
        .gpio_wdt (gpio_wdt),
        .gpio_rdt (gpio_rdt)
    );

    ////////////////////////////////////////////////////////////////////////////
    // subordinates
    ////////////////////////////////////////////////////////////////////////////

    tcb_memory mem (
        .clk     (clk),
        .mem_vld (mem_vld),
        .mem_wen (mem_wen),
        .mem_adr (mem_adr),
        .mem_siz (mem_siz),
        .mem_wdt (mem_wdt),
        .mem_rdt (mem_rdt)
    );

    tcb_gpio gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .gpio_vld (gpio_vld),
        .gpio_wen (gpio_wen),
        .gpio_adr (gpio_adr),
        .gpio_wdt (gpio_wdt),
        .gpio_rdt (gpio_rdt),
        .gpio_o   (gpio_o),
        .gpio_e   (gpio_e),
        .gpio_i   (gpio_i)
    );

endmodule: soc_top

`default_nettype wire

//--- tb_soc_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_soc_top;

    // random cycles after reset
    localparam int unsigned n_cycles = 3000;
    // longest wait on rdy
    localparam int unsigned wait_lim = 20;

    logic        clk;
    logic        rst_n;

    // manager requests, index is the port
    logic        vld [0:1];
    logic        wen [0:1];
    logic [31:0] adr [0:1];
    logic [1:0]  siz [0:1];
    logic [31:0] wdt [0:1];
    logic [31:0] gpio_i;

    // DUT outputs
    wire  [1:0]  rdy;
    wire  [1:0]  err;
    wire  [31:0] rdt0;
    wire  [31:0] rdt1;
    wire  [31:0] gpio_o;
    wire  [31:0] gpio_e;

    // reference model
    logic [31:0] mdl_mem [0:1023];
    // lanes written at least once
    logic [31:0] mdl_wrm [0:1023];
    logic [31:0] mdl_out;
    logic [31:0] mdl_ena;
    // last winner, 1 means port 1
    logic        mdl_lst;

    // expected response per port for the next cycle
    logic        exp_err [0:1];
    logic [31:0] exp_rdt [0:1];
    logic [31:0] exp_msk [0:1];
    // handshake at the coming edge
    logic        acc [0:1];
    int unsigned wait_cnt [0:1];

    logic [31:0] lfsr;
    int unsigned mismatches;
    int unsigned timeouts;
    logic        hung;

    soc_top dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .m0_vld (vld[0]),
        .m0_wen (wen[0]),
        .m0_adr (adr[0]),
        .m0_siz (siz[0]),
        .m0_wdt (wdt[0]),
        .m0_rdy (rdy[0]),
        .m0_rdt (rdt0),
        .m0_err (err[0]),
        .m1_vld (vld[1]),
        .m1_wen (wen[1]),
        .m1_adr (adr[1]),
        .m1_siz (siz[1]),
        .m1_wdt (wdt[1]),
        .m1_rdy (rdy[1]),
        .m1_rdt (rdt1),
        .m1_err (err[1]),
        .gpio_o (gpio_o),
        .gpio_e (gpio_e),
        .gpio_i (gpio_i)
    );

    // 100 ns period
    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // random numbers
    ////////////////////////////////////////////////////////////////////////////

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one step per bit, msb first
    task automatic random_bits(input int unsigned n, output logic [31:0] val);
        val = '0;
        for (int unsigned i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // address map rules
    ////////////////////////////////////////////////////////////////////////////

    // 0 memory, 1 GPIO, 2 error
    function automatic logic [1:0] target_of(input logic [31:0] a, input logic [1:0] s);
        logic ok;
        logic reg_hit;
        ok = (s == 2'd0) || (s == 2'd1 && !a[0]) || (s == 2'd2 && a[1:0] == 2'b00);
        reg_hit = (a[5:0] == soc_pkg::gpio_out_ofs) || (a[5:0] == soc_pkg::gpio_ena_ofs)
               || (a[5:0] == soc_pkg::gpio_in_ofs);
        if (!ok) begin
            return 2'd2;
        end
        if (a[31:13] == '0 && !a[12]) begin
            return 2'd0;
        end
        // GPIO takes word accesses only
        if (a[31:13] == '0 && a[12] && !a[6] && reg_hit && s == 2'd2) begin
            return 2'd1;
        end
        return 2'd2;
    endfunction

    // bytes ofs up to ofs + 2**s - 1
    function automatic logic [31:0] lane_mask(input logic [1:0] ofs, input logic [1:0] s);
        logic [31:0] m;
        int unsigned n;
        n = 1 << s;
        m = '0;
        for (int unsigned i = 0; i < 4; i++) begin
            if (i >= ofs && i < ofs + n) begin
                m[8*i+:8] = 8'hff;
            end
        end
        return m;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            mismatches++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // masked lanes only, unwritten memory bytes are ignored
    task automatic check_response(input int unsigned k);
        logic [31:0] act;
        act = (k == 1) ? rdt1 : rdt0;
        check_value($sformatf("m%0d err", k), {31'b0, exp_err[k]}, {31'b0, err[k]});
        check_value($sformatf("m%0d rdt", k), exp_rdt[k] & exp_msk[k], act & exp_msk[k]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic new_request(input int unsigned k, input logic force_vld);
        logic [31:0] r;
        logic [31:0] x;
        logic [2:0]  s3;
        logic [1:0]  ofs;
        logic        mis;
        random_bits(2, r);
        vld[k] = force_vld | (r[1:0] != 2'b00);
        random_bits(1, r);
        wen[k] = r[0];
        // one in eight picks the illegal size
        random_bits(3, r);
        s3 = r[2:0] % 3;
        siz[k] = (r[2:0] == 3'd7) ? 2'd3 : s3[1:0];
        // one in four keeps a raw offset
        random_bits(2, r);
        mis = (r[1:0] == 2'b00);
        random_bits(2, r);
        ofs = r[1:0];
        if (!mis) begin
            if (siz[k] == 2'd1) begin
                ofs[0] = 1'b0;
            end else if (siz[k] != 2'd0) begin
                ofs = 2'b00;
            end
        end
        // address class
        random_bits(2, r);
        case (r[1:0])
            // small window so reads hit written words
            2'd0, 2'd1: begin
                random_bits(4, x);
                adr[k] = {26'b0, x[3:0], ofs};
            end
            // GPIO group, 0x0c is not a register
            2'd2: begin
                random_bits(2, x);
                adr[k] = 32'h0000_1000 | {26'b0, x[1:0], ofs};
            end
            // unmapped, upper bits set or other peripheral group
            default: begin
                random_bits(1, x);
                adr[k] = x[0] ? (32'h0000_1040 | ofs) : (32'h0002_0000 | ofs);
            end
        endcase
        random_bits(32, r);
        wdt[k] = r;
    endtask

    // accepted or idle ports take a new request, waiting ones hold
    task automatic drive_ports(input logic first);
        logic [31:0] r;
        for (int unsigned k = 0; k < 2; k++) begin
            if (!vld[k] || acc[k]) begin
                new_request(k, first);
            end
        end
        random_bits(32, r);
        gpio_i = r;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // model
    ////////////////////////////////////////////////////////////////////////////

    // reads see the state before this edge's write
    task automatic model_transfer(input int unsigned k);
        logic [1:0]  tgt;
        logic [9:0]  idx;
        logic [31:0] bm;
        tgt = target_of(adr[k], siz[k]);
        idx = adr[k][11:2];
        exp_err[k] = (tgt == 2'd2);
        if (tgt == 2'd0) begin
            if (wen[k]) begin
                bm = lane_mask(adr[k][1:0], siz[k]);
                mdl_mem[idx] = (mdl_mem[idx] & ~bm) | (wdt[k] & bm);
                mdl_wrm[idx] = mdl_wrm[idx] | bm;
            end else begin
                exp_rdt[k] = mdl_mem[idx];
                exp_msk[k] = mdl_wrm[idx];
            end
        end else if (tgt == 2'd1) begin
            if (wen[k]) begin
                // input offset is read only
                if (adr[k][5:0] == soc_pkg::gpio_out_ofs) begin
                    mdl_out = wdt[k];
                end else if (adr[k][5:0] == soc_pkg::gpio_ena_ofs) begin
                    mdl_ena = wdt[k];
                end
            end else if (adr[k][5:0] == soc_pkg::gpio_out_ofs) begin
                exp_rdt[k] = mdl_out;
            end else if (adr[k][5:0] == soc_pkg::gpio_ena_ofs) begin
                exp_rdt[k] = mdl_ena;
            end else begin
                exp_rdt[k] = gpio_i;
            end
        end
        mdl_lst = (k == 1);
    endtask

    // mid cycle, inputs and outputs settled
    task automatic step_model();
        logic [1:0] gnt;
        check_response(0);
        check_response(1);
        check_value("gpio_o", mdl_out, gpio_o);
        check_value("gpio_e", mdl_ena, gpio_e);
        // quiet response unless a handshake follows
        for (int unsigned k = 0; k < 2; k++) begin
            exp_err[k] = 1'b0;
            exp_rdt[k] = '0;
            exp_msk[k] = '1;
        end
        // round robin
        if (vld[0] && vld[1]) begin
            // both asking, the port that did not win last time goes
            if (mdl_lst) begin
                gnt = 2'b01;
            end else begin
                gnt = 2'b10;
            end
        end else begin
            // a lone requester always wins
            gnt = {vld[1], vld[0]};
        end
        check_value("m0 rdy", {31'b0, gnt[0]}, {31'b0, rdy[0]});
        check_value("m1 rdy", {31'b0, gnt[1]}, {31'b0, rdy[1]});
        for (int unsigned k = 0; k < 2; k++) begin
            acc[k] = gnt[k];
            if (gnt[k]) begin
                model_transfer(k);
            end
            if (vld[k] && !gnt[k]) begin
                wait_cnt[k]++;
            end else begin
                wait_cnt[k] = 0;
            end
            if (wait_cnt[k] >= wait_lim) begin
                timeouts++;
                hung = 1'b1;
                $display("timeout: port %0d held vld for %0d cycles without rdy",
                         k, wait_cnt[k]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        gpio_i     = '0;
        lfsr       = 32'd94;
        mismatches = 0;
        timeouts   = 0;
        hung       = 1'b0;
        for (int unsigned k = 0; k < 2; k++) begin
            vld[k]      = 1'b0;
            wen[k]      = 1'b0;
            adr[k]      = '0;
            siz[k]      = '0;
            wdt[k]      = '0;
            acc[k]      = 1'b0;
            wait_cnt[k] = 0;
            exp_err[k]  = 1'b0;
            exp_rdt[k]  = '0;
            exp_msk[k]  = '1;
        end
        for (int unsigned i = 0; i < 1024; i++) begin
            mdl_mem[i] = '0;
            mdl_wrm[i] = '0;
        end
        mdl_out = '0;
        mdl_ena = '0;
        // port 0 first after reset
        mdl_lst = 1'b1;

        repeat (10) @(posedge clk);
        #5 rst_n = 1'b1;

        // idle after reset
        @(negedge clk);
        check_value("reset gpio_o", 32'h0, gpio_o);
        check_value("reset gpio_e", 32'h0, gpio_e);
        check_value("reset m0 err", 32'h0, {31'b0, err[0]});
        check_value("reset m1 err", 32'h0, {31'b0, err[1]});
        check_value("reset rdy", 32'h0, {30'b0, rdy});

        // first cycle contested on purpose
        for (int unsigned c = 0; c < n_cycles && !hung; c++) begin
            @(posedge clk);
            #5;
            drive_ports(c == 0);
            @(negedge clk);
            step_model();
        end

        // drain the last responses
        @(posedge clk);
        #5;
        vld[0] = 1'b0;
        vld[1] = 1'b0;
        @(negedge clk);
        check_response(0);
        check_response(1);
        check_value("gpio_o", mdl_out, gpio_o);
        check_value("gpio_e", mdl_ena, gpio_e);

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule: tb_soc_top

`default_nettype wire

//--- tcb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module tcb_arbiter (
    // system signals
    input  logic                      clk,
    input  logic                      rst_n,
    // manager port 0, core load/store
    input  logic                      m0_vld,
    input  logic                      m0_wen,
    input  logic [soc_pkg::xlen-1:0]  m0_adr,
    input  logic [soc_pkg::siz_w-1:0] m0_siz,
    input  logic [soc_pkg::xlen-1:0]  m0_wdt,
    output logic                      m0_rdy,
    output logic [soc_pkg::xlen-1:0]  m0_rdt,
    output logic                      m0_err,
    // manager port 1, DMA/debug
    input  logic                      m1_vld,
    input  logic                      m1_wen,
    input  logic [soc_pkg::xlen-1:0]  m1_adr,
    input  logic [soc_pkg::siz_w-1:0] m1_siz,
    input  logic [soc_pkg::xlen-1:0]  m1_wdt,
    output logic                      m1_rdy,
    output logic [soc_pkg::xlen-1:0]  m1_rdt,
    output logic                      m1_err,
    // shared system bus
    output logic                      bus_vld,
    output logic                      bus_wen,
    output logic [soc_pkg::xlen-1:0]  bus_adr,
    output logic [soc_pkg::siz_w-1:0] bus_siz,
    output logic [soc_pkg::xlen-1:0]  bus_wdt,
    input  logic                      bus_rdy,
    input  logic [soc_pkg::xlen-1:0]  bus_rdt,
    input  logic                      bus_err
);

    // request and grant, bit k for manager k
    logic [soc_pkg::n_man-1:0] req;
    logic [soc_pkg::n_man-1:0] gnt;
    // one-hot owner of the response in flight
    logic [soc_pkg::n_man-1:0] own;
    // last winner, 1 means port 1
    logic                      lst;
    // handshake on shared bus
    logic                      trf;

    ////////////////////////////////////////////////////////////////////////////
    // round-robin grant
    ////////////////////////////////////////////////////////////////////////////

    assign req = {m1_vld, m0_vld};

    // port 1 wins alone, or on contention when port 0 won last
    assign gnt[1] = req[1] & (~req[0] | ~lst);
    assign gnt[0] = req[0] & ~gnt[1];

    // ready only toward the winner
    assign m0_rdy = gnt[0] & bus_rdy;
    assign m1_rdy = gnt[1] & bus_rdy;

    ////////////////////////////////////////////////////////////////////////////
    // request multiplexer
    ////////////////////////////////////////////////////////////////////////////

    assign bus_vld = |req;
    assign bus_wen = gnt[1] ? m1_wen : m0_wen;
    assign bus_adr = gnt[1] ? m1_adr : m0_adr;
    assign bus_siz = gnt[1] ? m1_siz : m0_siz;
    assign bus_wdt = gnt[1] ? m1_wdt : m0_wdt;

    assign trf = bus_vld & bus_rdy;

    ////////////////////////////////////////////////////////////////////////////
    // response steering
    ////////////////////////////////////////////////////////////////////////////

    // port 0 gets priority out of reset, so pretend port 1 won last
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lst <= 1'b1;
            own <= '0;
        end else begin
            own <= trf ? gnt : '0;
            if (trf) begin
                lst <= gnt[1];
            end
        end
    end

    // loser sees a quiet response
    assign m0_rdt = own[0] ? bus_rdt : '0;
    assign m1_rdt = own[1] ? bus_rdt : '0;
    assign m0_err = own[0] & bus_err;
    assign m1_err = own[1] & bus_err;

endmodule: tcb_arbiter

`default_nettype wire

//--- tcb_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module tcb_decoder (
    // system signals
    input  logic                      clk,
    input  logic                      rst_n,
    // shared system bus
    input  logic                      bus_vld,
    input  logic                      bus_wen,
    input  logic [soc_pkg::xlen-1:0]  bus_adr,
    input  logic [soc_pkg::siz_w-1:0] bus_siz,
    input  logic [soc_pkg::xlen-1:0]  bus_wdt,
    output logic                      bus_rdy,
    output logic [soc_pkg::xlen-1:0]  bus_rdt,
    output logic                      bus_err,
    // data memory
    output logic                      mem_vld,
    output logic                      mem_wen,
    output logic [soc_pkg::xlen-1:0]  mem_adr,
    output logic [soc_pkg::siz_w-1:0] mem_siz,
    output logic [soc_pkg::xlen-1:0]  mem_wdt,
    input  logic [soc_pkg::xlen-1:0]  mem_rdt,
    // GPIO controller
    output logic                      gpio_vld,
    output logic                      gpio_wen,
    output logic [soc_pkg::xlen-1:0]  gpio_adr,
    output logic [soc_pkg::xlen-1:0]  gpio_wdt,
    input  logic [soc_pkg::xlen-1:0]  gpio_rdt
);

    // address seen through both views
    soc_pkg::tcb_adr_t adr;
    // offset fits the size, size legal
    logic              aln;
    // offset hits one of the GPIO registers
    logic              gpio_hit;
    // target selects
    logic              sel_mem;
    logic              sel_gpio;
    // handshake
    logic              trf;
    // response phase state
    logic              rsp_mem;
    logic              rsp_gpio;
    logic              rsp_err;
    logic              rsp_ren;

    assign adr = bus_adr;

    ////////////////////////////////////////////////////////////////////////////
    // request decoding
    ////////////////////////////////////////////////////////////////////////////

    // size 3 never legal
    always_comb begin
        case (bus_siz)
            2'd0:    aln = 1'b1;
            2'd1:    aln = ~adr.mem.ofs[0];
            2'd2:    aln = (adr.mem.ofs == 2'b00);
            default: aln = 1'b0;
        endcase
    end

    assign gpio_hit = (adr.per.ofs == soc_pkg::gpio_out_ofs)
                    | (adr.per.ofs == soc_pkg::gpio_ena_ofs)
                    | (adr.per.ofs == soc_pkg::gpio_in_ofs);

    // memory region, any legal aligned access
    assign sel_mem  = (adr.mem.top == '0) & ~adr.mem.rgn & aln;
    // GPIO group, word access only, register offsets are word aligned
    assign sel_gpio = (adr.per.top == '0) & adr.per.rgn & ~adr.per.grp
                    & gpio_hit & (bus_siz == 2'd2) & aln;

    // every subordinate is always ready
    assign bus_rdy = 1'b1;
    assign trf     = bus_vld & bus_rdy;

    // error transfers reach nobody
    assign mem_vld  = bus_vld & sel_mem;
    assign mem_wen  = bus_wen;
    assign mem_adr  = bus_adr;
    assign mem_siz  = bus_siz;
    assign mem_wdt  = bus_wdt;

    assign gpio_vld = bus_vld & sel_gpio;
    assign gpio_wen = bus_wen;
    assign gpio_adr = bus_adr;
    assign gpio_wdt = bus_wdt;

    ////////////////////////////////////////////////////////////////////////////
    // response multiplexer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_mem  <= 1'b0;
            rsp_gpio <= 1'b0;
            rsp_err  <= 1'b0;
            rsp_ren  <= 1'b0;
        end else begin
            rsp_mem  <= trf & sel_mem;
            rsp_gpio <= trf & sel_gpio;
            rsp_err  <= trf & ~sel_mem & ~sel_gpio;
            rsp_ren  <= trf & ~bus_wen;
        end
    end

    // read data only for reads; writes and errors return zero
    always_comb begin
        if (rsp_ren & rsp_mem) begin
            bus_rdt = mem_rdt;
        end else if (rsp_ren & rsp_gpio) begin
            bus_rdt = gpio_rdt;
        end else begin
            bus_rdt = '0;
        end
    end

    assign bus_err = rsp_err;

endmodule: tcb_decoder

`default_nettype wire

//--- tcb_gpio.sv
`timescale 1ns/10ps
`default_nettype none

module tcb_gpio (
    // system signals
    input  logic                     clk,
    input  logic                     rst_n,
    // request from decoder, always a word access
    input  logic                     gpio_vld,
    input  logic                     gpio_wen,
    input  logic [soc_pkg::xlen-1:0] gpio_adr,
    input  logic [soc_pkg::xlen-1:0] gpio_wdt,
    // response, one cycle later
    output logic [soc_pkg::xlen-1:0] gpio_rdt,
    // GPIO pins
    output logic [soc_pkg::xlen-1:0] gpio_o,
    output logic [soc_pkg::xlen-1:0] gpio_e,
    input  logic [soc_pkg::xlen-1:0] gpio_i
);

    // peripheral view of the address
    soc_pkg::tcb_adr_t adr;

    assign adr = gpio_adr;

    ////////////////////////////////////////////////////////////////////////////
    // output and enable registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_o <= '0;
            gpio_e <= '0;
        end else if (gpio_vld & gpio_wen) begin
            case (adr.per.ofs)
                soc_pkg::gpio_out_ofs: gpio_o <= gpio_wdt;
                soc_pkg::gpio_ena_ofs: gpio_e <= gpio_wdt;
                // input register is read only
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////////////////////

    // input pins sampled at the transfer edge
    // output and enable read back their register values
    always_ff @(posedge clk) begin
        if (gpio_vld & ~gpio_wen) begin
            case (adr.per.ofs)
                soc_pkg::gpio_out_ofs: gpio_rdt <= gpio_o;
                soc_pkg::gpio_ena_ofs: gpio_rdt <= gpio_e;
                soc_pkg::gpio_in_ofs:  gpio_rdt <= gpio_i;
                default:               gpio_rdt <= '0;
            endcase
        end
    end

endmodule: tcb_gpio

`default_nettype wire

//--- tcb_memory.sv
`timescale 1ns/10ps
`default_nettype none

module tcb_memory (
    // system signals
    input  logic                      clk,
    // request from decoder
    input  logic                      mem_vld,
    input  logic                      mem_wen,
    input  logic [soc_pkg::xlen-1:0]  mem_adr,
    input  logic [soc_pkg::siz_w-1:0] mem_siz,
    input  logic [soc_pkg::xlen-1:0]  mem_wdt,
    // response, one cycle later
    output logic [soc_pkg::xlen-1:0]  mem_rdt
);

    // word array, contents undefined after reset
    logic [soc_pkg::xlen-1:0]   ram [0:(2**soc_pkg::mem_adr)-1];

    // memory view of the address
    soc_pkg::tcb_adr_t          adr;
    // byte lane enables
    logic [soc_pkg::xlen/8-1:0] ben;

    assign adr = mem_adr;

    ////////////////////////////////////////////////////////////////////////////
    // byte enables
    ////////////////////////////////////////////////////////////////////////////

    // lanes shifted up by the byte offset
    // alignment is already checked by the decoder
    always_comb begin
        case (mem_siz)
            2'd0:    ben = 4'b0001 << adr.mem.ofs;
            2'd1:    ben = 4'b0011 << adr.mem.ofs;
            2'd2:    ben = 4'b1111;
            default: ben = 4'b0000;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // array access
    ////////////////////////////////////////////////////////////////////////////

    // write lane i from wdt lane i, no data rotation
    always_ff @(posedge clk) begin
        if (mem_vld & mem_wen) begin
            for (int unsigned i = 0; i < soc_pkg::xlen/8; i++) begin
                if (ben[i]) begin
                    ram[adr.mem.idx][8*i+:8] <= mem_wdt[8*i+:8];
                end
            end
        end
    end

    // whole word on read, size only matters for writes
    always_ff @(posedge clk) begin
        if (mem_vld & ~mem_wen) begin
            mem_rdt <= ram[adr.mem.idx];
        end
    end

endmodule: tcb_memory

`default_nettype wire
